//--- verilog/motor_pkg.sv
// motor speed loop definitions
package motor_pkg;

	// ==================================================
	// channel count and data widths
	// ==================================================
	localparam int num_motors = 2;               // motor channels built by the top

	typedef logic signed [31:0] count_t;          // encoder position
	typedef logic signed [15:0] speed_t;          // steps per sample window
	typedef logic        [7:0]  duty_t;           // pwm duty, also the pwm phase
	typedef logic        [16:0] gain_t;           // 9.8 fixed point gain
	typedef logic signed [1:0]  dir_t;            // 01 fwd, 11 rev, 00 stop
	typedef logic signed [17:0] err_t;            // error and integrator, room for +-65535
	typedef logic signed [47:0] acc_t;            // pid products and sum

	// speed saturation bounds
	localparam int speed_max = 2 ** ($bits(speed_t) - 1) - 1;
	localparam int speed_min = -(2 ** ($bits(speed_t) - 1));

	// ==================================================
	// timing
	// ==================================================
	localparam int sample_period = 250000;        // 5 ms at 50 MHz
	localparam int timer_w       = $clog2(sample_period);
	typedef logic [timer_w-1:0] timer_t;

	localparam int filter_len = 8;                // cycles a line must hold still
	typedef logic [$clog2(filter_len)-1:0] filter_cnt_t;

	localparam int pwm_period = 255;              // phase runs 0..254

	// pid scaling and limits
	localparam int gain_frac   = 8;               // fraction bits of the gains
	localparam int duty_max    = 255;
	localparam int integ_limit = 65535;           // integrator clamp, both signs

	// gray positions of the encoder, value is {a, b}
	typedef enum logic [1:0] {
		quad_00 = 2'b00,
		quad_01 = 2'b01,
		quad_11 = 2'b11,
		quad_10 = 2'b10
	} quad_state_t;

endpackage

//--- verilog/encoder_filter.sv
// encoder line filter
`timescale 1ns/100ps

module encoder_filter (
	input  logic fpga_clk_50,
	input  logic hps_fpga_reset_n,
	input  logic enc_a,
	input  logic enc_b,
	output logic enc_a_f,
	output logic enc_b_f
);
	import motor_pkg::*;

	logic [1:0]  sync_1;                          // bit 0 is a, bit 1 is b
	logic [1:0]  sync_2;                          // safe to use from here on
	logic [1:0]  filt;
	filter_cnt_t stable_cnt [2];                  // cycles the line has differed

	// two flop synchronizer
	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			sync_1 <= '0;
			sync_2 <= '0;
		end
		else
		begin
			sync_1 <= {enc_b, enc_a};
			sync_2 <= sync_1;
		end
	end

	// stability filter, one counter per line
	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			filt <= '0;
			for (int i = 0; i < 2; i++)
				stable_cnt[i] <= '0;
		end
		else
		begin
			for (int i = 0; i < 2; i++)
			begin
				if (sync_2[i] == filt[i])
					stable_cnt[i] <= '0;                  // glitch gone, start over
				else if (stable_cnt[i] == filter_cnt_t'(filter_len - 1))
				begin
					filt[i]       <= sync_2[i];           // held filter_len samples
					stable_cnt[i] <= '0;
				end
				else
					stable_cnt[i] <= stable_cnt[i] + 1'b1;
			end
		end
	end

	assign enc_a_f = filt[0];
	assign enc_b_f = filt[1];

endmodule

//--- verilog/quadrature_counter.sv
// quadrature position counter
`timescale 1ns/100ps

module quadrature_counter (
	input  logic             fpga_clk_50,
	input  logic             hps_fpga_reset_n,
	input  logic             enc_a_f,
	input  logic             enc_b_f,
	output motor_pkg::count_t count
);
	import motor_pkg::*;

	quad_state_t state;                           // last gray position seen
	quad_state_t cur;
	quad_state_t fwd_next;                        // position one step forward
	quad_state_t bwd_next;

	assign cur = quad_state_t'({enc_a_f, enc_b_f});

	// neighbours of the current position, forward is 00 01 11 10
	always_comb
	begin
		case (state)
			quad_00: begin fwd_next = quad_01; bwd_next = quad_10; end
			quad_01: begin fwd_next = quad_11; bwd_next = quad_00; end
			quad_11: begin fwd_next = quad_10; bwd_next = quad_01; end
			default: begin fwd_next = quad_00; bwd_next = quad_11; end
		endcase
	end

	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			state <= quad_00;
			count <= '0;
		end
		else
		begin
			state <= cur;                             // also resyncs after a bad jump
			if (cur == fwd_next)
				count <= count + count_t'(1);
			else if (cur == bwd_next)
				count <= count - count_t'(1);
			// both bits flipped: no step, count holds
		end
	end

	a_count_step: assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
		count_t'(count - $past(count)) inside {-1, 0, 1})
		else $error("encoder count moved by more than one step");

endmodule

//--- verilog/sample_timer.sv
// speed sample strobe
`timescale 1ns/100ps

module sample_timer (
	input  logic fpga_clk_50,
	input  logic hps_fpga_reset_n,
	output logic sample_tick
);
	import motor_pkg::*;

	timer_t tick_cnt;                             // 0 .. sample_period-1

	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			tick_cnt    <= '0;
			sample_tick <= 1'b0;
		end
		else if (tick_cnt == timer_t'(sample_period - 1))
		begin
			tick_cnt    <= '0;
			sample_tick <= 1'b1;                    // one cycle at the wrap
		end
		else
		begin
			tick_cnt    <= tick_cnt + 1'b1;
			sample_tick <= 1'b0;
		end
	end

	a_tick_single: assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
		sample_tick |=> !sample_tick)
		else $error("sample strobe held for two cycles");

endmodule

//--- verilog/speed_meter.sv
// window speed measurement
`timescale 1ns/100ps

module speed_meter (
	input  logic              fpga_clk_50,
	input  logic              hps_fpga_reset_n,
	input  logic              sample_tick,
	input  motor_pkg::count_t count,
	output motor_pkg::speed_t speed,
	output logic              speed_valid
);
	import motor_pkg::*;

	count_t last_count;                           // count at the previous tick
	count_t delta;                                // steps in this window

	assign delta = count - last_count;            // wraps cleanly on 32 bit rollover

	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			last_count  <= '0;                      // count also starts at 0
			speed       <= '0;
			speed_valid <= 1'b0;
		end
		else
		begin
			speed_valid <= sample_tick;             // pulse one cycle after the tick
			if (sample_tick)
			begin
				last_count <= count;
				// clip to the speed range
				if (delta > count_t'(speed_max))
					speed <= speed_t'(speed_max);
				else if (delta < count_t'(speed_min))
					speed <= speed_t'(speed_min);
				else
					speed <= speed_t'(delta);
			end
		end
	end

endmodule

//--- verilog/pid_controller.sv
// pid speed controller
`timescale 1ns/100ps

module pid_controller (
	input  logic              fpga_clk_50,
	input  logic              hps_fpga_reset_n,
	input  logic              speed_valid,
	input  motor_pkg::speed_t speed,
	input  motor_pkg::duty_t  setpoint_mag,
	input  motor_pkg::dir_t   setpoint_dir,
	input  motor_pkg::gain_t  kp,
	input  motor_pkg::gain_t  ki,
	input  motor_pkg::gain_t  kd,
	output motor_pkg::duty_t  duty,
	output logic              dir_a,
	output logic              dir_b
);
	import motor_pkg::*;

	err_t setpoint;                               // signed target, +-255
	err_t err_now;
	err_t integ;                                  // clamped running sum of error
	err_t integ_next;
	err_t prev_err;                               // error of the last window
	acc_t integ_sum;                              // unclamped, wide
	acc_t err_diff;
	acc_t u_sum;                                  // gains still in 9.8 format
	acc_t u;
	acc_t u_mag;

	// ==================================================
	// error terms
	// ==================================================
	assign setpoint  = err_t'($signed({1'b0, setpoint_mag})) * err_t'(setpoint_dir);
	assign err_now   = setpoint - err_t'(speed);
	assign integ_sum = acc_t'(integ) + acc_t'(err_now);
	assign err_diff  = acc_t'(err_now) - acc_t'(prev_err);

	// integrator clamp, both signs
	always_comb
	begin
		if (integ_sum > acc_t'(integ_limit))
			integ_next = err_t'(integ_limit);
		else if (integ_sum < -acc_t'(integ_limit))
			integ_next = -err_t'(integ_limit);
		else
			integ_next = err_t'(integ_sum);
	end

	// ==================================================
	// control output
	// ==================================================
	// gains are unsigned, zero extend before the signed multiply
	assign u_sum = acc_t'($signed({1'b0, kp})) * acc_t'(err_now)
		+ acc_t'($signed({1'b0, ki})) * acc_t'(integ_next)
		+ acc_t'($signed({1'b0, kd})) * err_diff;
	assign u     = u_sum >>> gain_frac;           // drop the fraction, keep sign
	assign u_mag = (u < 0) ? -u : u;

	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			integ    <= '0;
			prev_err <= '0;
			duty     <= '0;
			dir_a    <= 1'b0;
			dir_b    <= 1'b0;
		end
		else if (speed_valid)                     // once per window
		begin
			integ    <= integ_next;
			prev_err <= err_now;
			duty     <= (u_mag > acc_t'(duty_max)) ? duty_t'(duty_max) : duty_t'(u_mag);
			dir_a    <= (u > 0);                    // bridge 10 forward
			dir_b    <= (u < 0);                    // bridge 01 reverse, 00 brake
		end
	end

	a_dir_exclusive: assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
		!(dir_a && dir_b))
		else $error("both bridge direction pins high");

endmodule

//--- verilog/pwm_generator.sv
// motor pwm output
`timescale 1ns/100ps

module pwm_generator (
	input  logic             fpga_clk_50,
	input  logic             hps_fpga_reset_n,
	input  motor_pkg::duty_t duty,
	output logic             pwm
);
	import motor_pkg::*;

	duty_t phase;                                 // 0 .. pwm_period-1
	duty_t duty_q;                                // duty for the running period

	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			phase  <= '0;
			duty_q <= '0;
			pwm    <= 1'b0;
		end
		else
		begin
			if (phase == duty_t'(pwm_period - 1))
			begin
				phase  <= '0;
				duty_q <= duty;                       // new duty lands with phase 0
			end
			else
				phase <= phase + 1'b1;
			// registered, one cycle behind the phase
			pwm <= (phase < duty_q);                // 255 never drops, phase tops at 254
		end
	end

endmodule

//--- verilog/motor_control_top.sv
// motor speed loop top
`timescale 1ns/100ps

module motor_control_top (
	input  logic                               fpga_clk_50,
	input  logic                               hps_fpga_reset_n,
	input  logic [motor_pkg::num_motors-1:0]   enc_a,
	input  logic [motor_pkg::num_motors-1:0]   enc_b,
	input  motor_pkg::duty_t  setpoint_mag     [motor_pkg::num_motors],
	input  motor_pkg::dir_t   setpoint_dir     [motor_pkg::num_motors],
	input  motor_pkg::gain_t  kp               [motor_pkg::num_motors],
	input  motor_pkg::gain_t  ki               [motor_pkg::num_motors],
	input  motor_pkg::gain_t  kd               [motor_pkg::num_motors],
	output motor_pkg::count_t count            [motor_pkg::num_motors],
	output motor_pkg::duty_t  duty             [motor_pkg::num_motors],
	output logic [motor_pkg::num_motors-1:0]   pwm,
	output logic [motor_pkg::num_motors-1:0]   dir_a,
	output logic [motor_pkg::num_motors-1:0]   dir_b
);
	import motor_pkg::*;

	logic sample_tick;                            // shared 5 ms strobe

	sample_timer i_sample_timer (
		.fpga_clk_50      (fpga_clk_50),
		.hps_fpga_reset_n (hps_fpga_reset_n),
		.sample_tick      (sample_tick)
	);

	// ==================================================
	// one speed loop per motor
	// ==================================================
	for (genvar m = 0; m < num_motors; m++)
	begin : g_motor
		logic   enc_a_f;
		logic   enc_b_f;
		speed_t speed;
		logic   speed_valid;

		encoder_filter i_encoder_filter (
			.fpga_clk_50 (fpga_clk_50), .hps_fpga_reset_n (hps_fpga_reset_n),
			.enc_a       (enc_a[m]),    .enc_b            (enc_b[m]),
			.enc_a_f     (enc_a_f),     .enc_b_f          (enc_b_f)
		);

		quadrature_counter i_quadrature_counter (
			.fpga_clk_50 (fpga_clk_50), .hps_fpga_reset_n (hps_fpga_reset_n),
			.enc_a_f     (enc_a_f),     .enc_b_f          (enc_b_f),
			.count       (count[m])                  // also exported
		);

		speed_meter i_speed_meter (
			.fpga_clk_50 (fpga_clk_50), .hps_fpga_reset_n (hps_fpga_reset_n),
			.sample_tick (sample_tick), .count            (count[m]),
			.speed       (speed),       .speed_valid      (speed_valid)
		);

		pid_controller i_pid_controller (
			.fpga_clk_50  (fpga_clk_50),     .hps_fpga_reset_n (hps_fpga_reset_n),
			.speed_valid  (speed_valid),     .speed            (speed),
			.setpoint_mag (setpoint_mag[m]), .setpoint_dir     (setpoint_dir[m]),
			.kp (kp[m]), .ki (ki[m]), .kd (kd[m]),
			.duty         (duty[m]),         // to pwm and the port
			.dir_a        (dir_a[m]),        .dir_b            (dir_b[m])
		);

		pwm_generator i_pwm_generator (
			.fpga_clk_50 (fpga_clk_50), .hps_fpga_reset_n (hps_fpga_reset_n),
			.duty        (duty[m]),     .pwm              (pwm[m])
		);
	end

endmodule

//--- verification/tb_motor_control.sv
// motor speed loop testbench
`timescale 1ns/100ps

module tb_motor_control;
	import motor_pkg::*;

	// ==================================================
	// test constants
	// ==================================================
	localparam int clk_half       = 4;                  // 8 ns clock
	localparam int drive_delay    = 1;                  // inputs move 1 ns after the edge
	localparam int reset_cycles   = 5;
	localparam int seed           = 9550;
	localparam int hold_cycles    = 16;                 // one gray level
	localparam int short_pulse    = 4;                  // below the filter length
	localparam int num_windows    = 8;                  // windows the compare process checks
	localparam int sp             = sample_period;
	localparam int timeout_cycles = 15 * sample_period;

	logic fpga_clk_50 = 1'b0;
	logic hps_fpga_reset_n;
	logic [num_motors-1:0] enc_a;
	logic [num_motors-1:0] enc_b;
	duty_t  setpoint_mag [num_motors];
	dir_t   setpoint_dir [num_motors];
	gain_t  kp [num_motors];
	gain_t  ki [num_motors];
	gain_t  kd [num_motors];
	count_t count [num_motors];
	duty_t  duty [num_motors];
	logic [num_motors-1:0] pwm;
	logic [num_motors-1:0] dir_a;
	logic [num_motors-1:0] dir_b;

	// model of each channel
	logic [1:0] gray_seq [4] = '{2'b00, 2'b01, 2'b11, 2'b10};  // forward order as {a, b}
	int     gray_idx [num_motors];
	int     pos [num_motors];                           // steps made so far
	int     last_pos [num_motors];                      // pos at the previous tick
	longint integ_m [num_motors];
	longint perr_m [num_motors];
	longint exp_duty [num_motors];
	int     exp_dir [num_motors];                       // {dir_a, dir_b}
	int     cyc;                                        // posedges since reset release
	bit     checks_done;

	motor_control_top i_dut (
		.fpga_clk_50      (fpga_clk_50),
		.hps_fpga_reset_n (hps_fpga_reset_n),
		.enc_a            (enc_a),
		.enc_b            (enc_b),
		.setpoint_mag     (setpoint_mag),
		.setpoint_dir     (setpoint_dir),
		.kp               (kp),
		.ki               (ki),
		.kd               (kd),
		.count            (count),
		.duty             (duty),
		.pwm              (pwm),
		.dir_a            (dir_a),
		.dir_b            (dir_b)
	);

	always #(clk_half) fpga_clk_50 = ~fpga_clk_50;

	always @(posedge fpga_clk_50)
		if (hps_fpga_reset_n)
			cyc <= cyc + 1;

	// ==================================================
	// helpers
	// ==================================================
	task automatic next_cycle();
		@(posedge fpga_clk_50);
		#(drive_delay);
	endtask

	task automatic wait_cycle(input int n);
		while (cyc < n)
			next_cycle();
	endtask

	task automatic check_val(input string name, input longint expected, input longint actual);
		if (expected != actual)
		begin
			$display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
			$display("Result: FAILED");
			$fatal(1, "stopped at first error");
		end
	endtask

	// signed target as mag times dir
	function automatic longint signed_target(input duty_t mag, input dir_t dir);
		case (dir)
			2'b01:   return longint'(mag);
			2'b11:   return -longint'(mag);
			default: return 0;
		endcase
	endfunction

	// expected pid output before duty saturation
	function automatic longint pid_ref(input longint target, input longint speed_steps,
		input longint kp_g, input longint ki_g, input longint kd_g,
		input longint integ_prev, input longint err_prev, output longint integ_out);
		longint err;
		longint sum;
		err       = target - speed_steps;
		integ_out = integ_prev + err;
		if (integ_out > longint'(integ_limit))
			integ_out = longint'(integ_limit);               // clamp high
		else if (integ_out < -longint'(integ_limit))
			integ_out = -longint'(integ_limit);
		sum = kp_g * err + ki_g * integ_out + kd_g * (err - err_prev);
		return sum >>> gain_frac;
	endfunction

	// gray steps on one channel with a count check after each
	task automatic move(input int ch, input bit fwd, input int steps);
		repeat (steps)
		begin
			gray_idx[ch] = fwd ? (gray_idx[ch] + 1) % 4 : (gray_idx[ch] + 3) % 4;
			{enc_a[ch], enc_b[ch]} = gray_seq[gray_idx[ch]];
			pos[ch] = fwd ? pos[ch] + 1 : pos[ch] - 1;
			repeat (hold_cycles) next_cycle();           // filter plus counter fit in 16
			check_val($sformatf("step ch%0d", ch), longint'(pos[ch]), longint'(count[ch]));
		end
	endtask

	// short pulse then a two bit jump out and back
	task automatic glitch_checks(input int ch);
		enc_a[ch] = ~enc_a[ch];
		for (int i = 0; i < short_pulse + hold_cycles; i++)
		begin
			next_cycle();
			if (i == short_pulse - 1)
				enc_a[ch] = ~enc_a[ch];                   // pulse ends
			// a pulse that got through would move count and then move it back
			check_val($sformatf("pulse ch%0d", ch), longint'(pos[ch]), longint'(count[ch]));
		end
		repeat (2)
		begin
			{enc_a[ch], enc_b[ch]} = ~{enc_a[ch], enc_b[ch]};
			repeat (hold_cycles) next_cycle();
			check_val($sformatf("jump ch%0d", ch), longint'(pos[ch]), longint'(count[ch]));
		end
	endtask

	// high cycles over one full pwm period
	task automatic check_pwm();
		int high [num_motors];
		for (int ch = 0; ch < num_motors; ch++)
			high[ch] = 0;
		wait_cycle((cyc / pwm_period + 1) * pwm_period + 1);  // first cycle of a period
		repeat (pwm_period)
		begin
			for (int ch = 0; ch < num_motors; ch++)
				if (pwm[ch])
					high[ch]++;
			next_cycle();
		end
		for (int ch = 0; ch < num_motors; ch++)
			check_val($sformatf("pwm width ch%0d", ch), exp_duty[ch], longint'(high[ch]));
	endtask

	// ==================================================
	// compare process with one pass per sample window
	// ==================================================
	initial
	begin : compare_windows
		longint target;
		longint speed_steps;
		longint integ_new;
		longint u;
		for (int w = 1; w <= num_windows; w++)
		begin
			wait_cycle(w * sp);                             // tick with no steps nearby
			for (int ch = 0; ch < num_motors; ch++)
			begin
				target       = signed_target(setpoint_mag[ch], setpoint_dir[ch]);
				speed_steps  = longint'(pos[ch] - last_pos[ch]);
				last_pos[ch] = pos[ch];
				u = pid_ref(target, speed_steps, longint'(kp[ch]), longint'(ki[ch]),
					longint'(kd[ch]), integ_m[ch], perr_m[ch], integ_new);
				integ_m[ch]  = integ_new;
				perr_m[ch]   = target - speed_steps;
				exp_duty[ch] = (u < 0) ? -u : u;
				if (exp_duty[ch] > longint'(duty_max))
					exp_duty[ch] = longint'(duty_max);       // duty saturates
				exp_dir[ch]  = (u > 0) ? 2 : ((u < 0) ? 1 : 0);
			end
			wait_cycle(w * sp + sp / 2);                    // mid window
			for (int ch = 0; ch < num_motors; ch++)
			begin
				check_val($sformatf("window %0d duty ch%0d", w, ch), exp_duty[ch],
					longint'(duty[ch]));
				check_val($sformatf("window %0d dir ch%0d", w, ch), longint'(exp_dir[ch]),
					longint'({dir_a[ch], dir_b[ch]}));
			end
		end
		checks_done = 1'b1;
	end

	initial
	begin : watchdog
		repeat (timeout_cycles) @(posedge fpga_clk_50);
		$display("timeout: the tests did not finish within %0d clock cycles", timeout_cycles);
		$display("Result: FAILED");
		$fatal(1, "watchdog expired");
	end

	// ==================================================
	// stimulus
	// ==================================================
	initial
	begin : main
		hps_fpga_reset_n = 1'b0;
		enc_a = '0;
		enc_b = '0;
		for (int ch = 0; ch < num_motors; ch++)
		begin
			setpoint_mag[ch] = '0;
			setpoint_dir[ch] = '0;
			kp[ch] = '0;
			ki[ch] = '0;
			kd[ch] = '0;
		end
		void'($urandom(seed));
		repeat (reset_cycles) @(posedge fpga_clk_50);
		#(drive_delay) hps_fpga_reset_n = 1'b1;

		// everything starts at zero
		for (int ch = 0; ch < num_motors; ch++)
		begin
			check_val($sformatf("reset count ch%0d", ch), 0, longint'(count[ch]));
			check_val($sformatf("reset duty ch%0d", ch), 0, longint'(duty[ch]));
			check_val($sformatf("reset pwm ch%0d", ch), 0, longint'(pwm[ch]));
			check_val($sformatf("reset dir ch%0d", ch), 0, longint'({dir_a[ch], dir_b[ch]}));
		end

		// counting all done in window 0
		move(0, 1'b1, 6);
		move(0, 1'b0, 3);
		move(1, 1'b0, 5);
		move(1, 1'b1, 2);
		glitch_checks(0);
		glitch_checks(1);

		// proportional only with the motor standing
		wait_cycle(sp + 3 * sp / 4);
		for (int ch = 0; ch < num_motors; ch++)
		begin
			setpoint_mag[ch] = duty_t'($urandom_range(255, 1));
			setpoint_dir[ch] = 2'b01;
			kp[ch]           = gain_t'($urandom_range(1023, 1));
		end
		wait_cycle(2 * sp + 3 * sp / 4);
		for (int ch = 0; ch < num_motors; ch++)
		begin
			setpoint_mag[ch] = duty_t'($urandom_range(255, 128));
			kp[ch]           = gain_t'($urandom_range(131071, 65536));  // drives duty to 255
		end
		wait_cycle(3 * sp + sp / 2 + 500);
		check_pwm();

		// full pid with channel 0 in reverse
		wait_cycle(3 * sp + 3 * sp / 4);
		setpoint_mag[1] = duty_t'($urandom_range(255, 1));
		kp[1]           = gain_t'($urandom_range(511, 16));
		ki[1]           = gain_t'($urandom_range(63, 1));
		kd[1]           = gain_t'($urandom_range(255, 1));
		setpoint_mag[0] = duty_t'($urandom_range(255, 1));
		setpoint_dir[0] = 2'b11;
		kp[0]           = gain_t'($urandom_range(511, 16));
		kd[0]           = gain_t'($urandom_range(255, 1));

		for (int w = 4; w < 8; w++)
		begin
			wait_cycle(w * sp + sp / 8);                    // steps far from both ticks
			move(1, $urandom_range(1, 0) == 1, int'($urandom_range(40, 5)));
			if (w == 4)
			begin
				wait_cycle(4 * sp + sp / 2 + 10);
				check_val("reverse dir ch0", 1, longint'({dir_a[0], dir_b[0]}));
				check_pwm();
			end
			else if (w == 5)
			begin
				wait_cycle(5 * sp + 3 * sp / 4);
				setpoint_dir[0] = 2'b00;                    // stop
				kd[0]           = '0;
			end
			else if (w == 6)
			begin
				wait_cycle(6 * sp + sp / 2 + 10);
				check_val("stop duty ch0", 0, longint'(duty[0]));
				check_val("stop dir ch0", 0, longint'({dir_a[0], dir_b[0]}));
				check_pwm();
			end
		end

		wait (checks_done);
		$display("Result: PASSED");
		$finish;
	end

endmodule

//--- filelist.f
verilog/motor_pkg.sv
verilog/encoder_filter.sv
verilog/quadrature_counter.sv
verilog/sample_timer.sv
verilog/speed_meter.sv
verilog/pid_controller.sv
verilog/pwm_generator.sv
verilog/motor_control_top.sv
verification/tb_motor_control.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the motor control testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_motor_control \
	-Mdir obj_dir -f filelist.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vtb_motor_control
status=$?
if [ $status -ne 0 ]; then
	echo "simulation ended with status $status"
	exit $status
fi
echo "simulation ended cleanly"
exit 0
